/* flist.f */
isa_pkg.sv
pipe_pkg.sv
control_decoder.sv
hazard_detector.sv
register_file.sv
branch_resolver.sv
id_ex_register.sv
drain_timer.sv
debug_controller.sv
decode_stage.sv
tb_decode_stage.sv

/* tb_decode_stage.sv */
`timescale 1ns/100ps
module tb_decode_stage;

	localparam int DRAIN_CYCLES   = 4;                  // Non-default drain length
	localparam int TIMEOUT_CYCLES = 50;                 // Cycle limit of every wait loop

	logic                        i_clock;
	logic                        i_reset;
	isa_pkg::instr_u             i_instr;
	logic [31:0]                 i_pc_plus4;
	logic                        i_enable;
	pipe_pkg::wb_port_t          i_wb;
	logic [4:0]                  i_ex_rt;
	logic                        i_ex_mem_read;
	logic                        i_forward_a;
	logic                        i_forward_b;
	logic [31:0]                 i_ex_mem_data;
	pipe_pkg::dbg_req_t          i_dbg;
	pipe_pkg::id_ex_t            o_id_ex;
	logic                        o_branch_taken;
	logic [31:0]                 o_branch_target;
	logic [31:0]                 o_jump_target;
	logic                        o_pc_write;
	logic                        o_if_id_write;
	logic                        o_halted;
	pipe_pkg::dbg_rsp_t          o_dbg;

	logic [31:0] reg_model [32];                        // Expected bank contents
	logic [31:0] rng_state = 32'h8cda_7ec2;

	decode_stage #(.DRAIN_CYCLES(DRAIN_CYCLES)) dut0 (.i_clock(i_clock), .i_reset(i_reset),
		.i_instr(i_instr), .i_pc_plus4(i_pc_plus4), .i_enable(i_enable), .i_wb(i_wb),
		.i_ex_rt(i_ex_rt), .i_ex_mem_read(i_ex_mem_read), .i_forward_a(i_forward_a),
		.i_forward_b(i_forward_b), .i_ex_mem_data(i_ex_mem_data), .i_dbg(i_dbg),
		.o_id_ex(o_id_ex), .o_branch_taken(o_branch_taken), .o_branch_target(o_branch_target),
		.o_jump_target(o_jump_target), .o_pc_write(o_pc_write), .o_if_id_write(o_if_id_write),
		.o_halted(o_halted), .o_dbg(o_dbg));

	initial
	begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;                 // 20 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic isa_pkg::instr_u rtype_word(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		isa_pkg::instr_u w;
		w = {isa_pkg::OP_RTYPE, rs, rt, rd, shamt, funct};  // Fields in MIPS order
		return w;
	endfunction

	function automatic isa_pkg::instr_u itype_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		isa_pkg::instr_u w;
		w = {op, rs, rt, imm};
		return w;
	endfunction

	function automatic isa_pkg::instr_u jtype_word(input logic [5:0] op, input logic [25:0] tgt);
		isa_pkg::instr_u w;
		w = {op, tgt};
		return w;
	endfunction

	task automatic report_fail;
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			report_fail();
		end
	endtask

	task automatic next_cycle;
		@(posedge i_clock);
		@(negedge i_clock);                             // Back on the drive edge
	endtask

	task automatic poll_halted(output int edges);
		edges = 0;
		while (o_halted !== 1'b1 && edges < TIMEOUT_CYCLES)
		begin
			next_cycle();
			edges++;
			if (o_halted !== 1'b1)
				check_eq("ack before halted", o_dbg.ack, 1'b0);
			check_eq("pc_write during drain", o_pc_write, 1'b0);
		end
		if (o_halted !== 1'b1)
		begin
			$display("Timeout: o_halted never rose after the HALT was captured");
			report_fail();
		end
	endtask

	task automatic poll_ack(input logic level);
		int cycles;
		cycles = 0;
		while (o_dbg.ack !== level && cycles < TIMEOUT_CYCLES)
		begin
			next_cycle();
			cycles++;
		end
		if (o_dbg.ack !== level)
		begin
			$display("Timeout: debug ack did not reach level %0b", level);
			report_fail();
		end
	endtask

	task automatic rtype_decode;
		i_enable = 1'b1;
		i_instr  = rtype_word(5'd3, 5'd4, 5'd5, 5'd7, isa_pkg::FN_ADD);
		next_cycle();
		check_eq("R rs", o_id_ex.rs, 5'd3);
		check_eq("R rt", o_id_ex.rt, 5'd4);
		check_eq("R rd", o_id_ex.rd, 5'd5);
		check_eq("R shamt", o_id_ex.shamt, 5'd7);
		check_eq("R funct", o_id_ex.funct, isa_pkg::FN_ADD);
		check_eq("R reg_dst", o_id_ex.ctrl.ex.reg_dst, 1'b1);
		check_eq("R alu_src", o_id_ex.ctrl.ex.alu_src, 1'b0);
		check_eq("R reg_write", o_id_ex.ctrl.wb.reg_write, 1'b1);
		i_enable = 1'b0;                                // Latch must hold
		i_instr  = rtype_word(5'd9, 5'd10, 5'd11, 5'd1, isa_pkg::FN_SUB);
		next_cycle();
		check_eq("hold rd", o_id_ex.rd, 5'd5);
		check_eq("hold funct", o_id_ex.funct, isa_pkg::FN_ADD);
	endtask

	task automatic regbank_and_imm;
		i_enable = 1'b1;
		for (int k = 1; k <= 10; k++)
		begin
			rng_state = xorshift32(rng_state);
			i_wb.we   = 1'b1;
			i_wb.addr = 5'(k);
			i_wb.data = rng_state;
			i_instr   = rtype_word(5'(k), 5'd0, 5'd0, 5'd0, isa_pkg::FN_ADD);
			next_cycle();
			reg_model[k] = rng_state;
			check_eq("write-through port A", o_id_ex.data_a, rng_state);
		end
		rng_state = xorshift32(rng_state);
		i_wb.addr = 5'd0;                               // Write to r0 is dropped
		i_wb.data = rng_state;
		i_instr   = rtype_word(5'd0, 5'd0, 5'd0, 5'd0, isa_pkg::FN_ADD);
		next_cycle();
		check_eq("r0 port A", o_id_ex.data_a, 32'h0);
		check_eq("r0 port B", o_id_ex.data_b, 32'h0);
		i_wb.we = 1'b0;
		for (int k = 1; k <= 9; k++)
		begin
			i_instr = rtype_word(5'(k), 5'(k + 1), 5'd0, 5'd0, isa_pkg::FN_OR);
			next_cycle();
			check_eq("readback A", o_id_ex.data_a, reg_model[k]);
			check_eq("readback B", o_id_ex.data_b, reg_model[k + 1]);
		end
		i_instr = itype_word(isa_pkg::OP_ADDI, 5'd1, 5'd2, 16'hFFF0);
		next_cycle();
		check_eq("ADDI sign ext", o_id_ex.imm_ext, 32'hFFFF_FFF0);
		check_eq("ADDI alu_src", o_id_ex.ctrl.ex.alu_src, 1'b1);
		i_instr = itype_word(isa_pkg::OP_ORI, 5'd1, 5'd2, 16'h8001);
		next_cycle();
		check_eq("ORI zero ext", o_id_ex.imm_ext, 32'h0000_8001);
		i_enable = 1'b0;
	endtask

	task automatic branch_case(input isa_pkg::instr_u instr, input logic fa, input logic fb,
		input logic [31:0] fwd, input logic exp_taken, input logic [31:0] exp_target);
		i_instr       = instr;
		i_forward_a   = fa;
		i_forward_b   = fb;
		i_ex_mem_data = fwd;
		#2;                                             // Outputs are combinational
		check_eq("branch taken", o_branch_taken, exp_taken);
		check_eq("branch target", o_branch_target, exp_target);
		next_cycle();
	endtask

	task automatic branch_jump;
		i_pc_plus4 = 32'h0000_1000;
		branch_case(itype_word(isa_pkg::OP_BEQ, 5'd1, 5'd1, 16'hFFFE), 0, 0, 0, 1, 32'h0000_0FF8);
		branch_case(itype_word(isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0010), 0, 0, 0,
			reg_model[1] == reg_model[2], 32'h0000_1040);
		branch_case(itype_word(isa_pkg::OP_BNE, 5'd1, 5'd2, 16'h0010), 0, 0, 0,
			reg_model[1] != reg_model[2], 32'h0000_1040);
		branch_case(itype_word(isa_pkg::OP_BNE, 5'd3, 5'd3, 16'h0004), 0, 0, 0, 0, 32'h0000_1010);
		// Forwarded value stands in for one operand
		branch_case(itype_word(isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0010), 1, 0, reg_model[2],
			1, 32'h0000_1040);
		branch_case(itype_word(isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0010), 0, 1, reg_model[1],
			1, 32'h0000_1040);
		branch_case(itype_word(isa_pkg::OP_BNE, 5'd4, 5'd4, 16'h0010), 1, 0, ~reg_model[4],
			1, 32'h0000_1040);
		i_pc_plus4 = 32'hA000_0004;
		i_instr    = jtype_word(isa_pkg::OP_J, 26'h2AB_CDEF);
		#2;
		check_eq("J taken", o_branch_taken, 1'b1);
		check_eq("J target", o_jump_target, 32'hAAAF_37BC);
		next_cycle();
		i_instr     = itype_word(isa_pkg::OP_ADDI, 5'd1, 5'd1, 16'h0001);
		i_forward_a = 1'b0;
		i_forward_b = 1'b0;
		#2;
		check_eq("ADDI not taken", o_branch_taken, 1'b0);
		next_cycle();
	endtask

	task automatic load_use_stall;
		i_enable      = 1'b1;
		i_ex_mem_read = 1'b1;
		i_instr       = rtype_word(5'd3, 5'd4, 5'd5, 5'd0, isa_pkg::FN_ADD);
		for (int k = 3; k <= 4; k++)
		begin
			i_ex_rt = 5'(k);                            // Match on rs, then on rt
			#2;
			check_eq("stall pc_write", o_pc_write, 1'b0);
			check_eq("stall if_id_write", o_if_id_write, 1'b0);
			next_cycle();
			check_eq("bubble ctrl", o_id_ex.ctrl, 9'h0);
		end
		i_ex_rt = 5'd7;
		#2;
		check_eq("no match pc_write", o_pc_write, 1'b1);
		next_cycle();
		check_eq("no bubble reg_write", o_id_ex.ctrl.wb.reg_write, 1'b1);
		i_ex_rt = 5'd0;                                 // r0 load is no dependency
		i_instr = rtype_word(5'd0, 5'd0, 5'd5, 5'd0, isa_pkg::FN_ADD);
		#2;
		check_eq("r0 no stall", o_if_id_write, 1'b1);
		next_cycle();
		i_ex_mem_read = 1'b0;
	endtask

	task automatic halt_and_debug;
		int edges;
		i_instr    = rtype_word(5'd0, 5'd0, 5'd0, 5'd0, isa_pkg::FN_SLL);
		i_dbg.addr = 5'd5;
		i_dbg.req  = 1'b1;                              // Early request must wait
		for (int k = 0; k < 3; k++)
		begin
			next_cycle();
			check_eq("early ack", o_dbg.ack, 1'b0);
		end
		i_instr = jtype_word(isa_pkg::OP_HALT, 26'h0);
		#2;
		check_eq("HALT pc_write", o_pc_write, 1'b0);
		check_eq("HALT if_id_write", o_if_id_write, 1'b0);
		next_cycle();                                   // HALT captured here
		check_eq("halted at capture", o_halted, 1'b0);
		poll_halted(edges);
		check_eq("drain edges", edges, DRAIN_CYCLES + 1);
		i_instr = rtype_word(5'd1, 5'd2, 5'd3, 5'd0, isa_pkg::FN_ADD);
		#2;
		check_eq("pc_write after halt", o_pc_write, 1'b0);
		poll_ack(1'b1);
		check_eq("early read data", o_dbg.data, reg_model[5]);
		i_dbg.req = 1'b0;
		poll_ack(1'b0);
		for (int a = 0; a <= 10; a++)
		begin
			i_dbg.addr = 5'(a);
			i_dbg.req  = 1'b1;
			poll_ack(1'b1);
			check_eq("debug read data", o_dbg.data, reg_model[a]);
			i_dbg.req = 1'b0;
			poll_ack(1'b0);                             // ack falls after req drops
		end
		check_eq("halted sticky", o_halted, 1'b1);
	endtask

	initial
	begin
		i_reset       = 1'b1;
		i_instr       = '0;
		i_pc_plus4    = '0;
		i_enable      = 1'b0;
		i_wb          = '0;
		i_ex_rt       = '0;
		i_ex_mem_read = 1'b0;
		i_forward_a   = 1'b0;
		i_forward_b   = 1'b0;
		i_ex_mem_data = '0;
		i_dbg         = '0;
		for (int k = 0; k < 32; k++)
			reg_model[k] = '0;                          // Reset clears the bank
		repeat (16) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		check_eq("reset id_ex", |o_id_ex, 1'b0);
		check_eq("reset halted", o_halted, 1'b0);
		check_eq("reset ack", o_dbg.ack, 1'b0);
		check_eq("reset taken", o_branch_taken, 1'b0);
		check_eq("reset pc_write", o_pc_write, 1'b1);
		check_eq("reset if_id_write", o_if_id_write, 1'b1);
		rtype_decode();
		regbank_and_imm();
		branch_jump();
		load_use_stall();
		halt_and_debug();
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps
module decode_stage
#(
	parameter int DRAIN_CYCLES = 3
)
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  isa_pkg::instr_u             i_instr,          // IF/ID word
	input  logic [isa_pkg::NB_DATA-1:0] i_pc_plus4,
	input  logic                        i_enable,
	input  pipe_pkg::wb_port_t          i_wb,
	input  logic [isa_pkg::NB_REG-1:0]  i_ex_rt,          // From ID/EX latch
	input  logic                        i_ex_mem_read,
	input  logic                        i_forward_a,      // Forwarding unit selects
	input  logic                        i_forward_b,
	input  logic [isa_pkg::NB_DATA-1:0] i_ex_mem_data,
	input  pipe_pkg::dbg_req_t          i_dbg,
	output pipe_pkg::id_ex_t            o_id_ex,
	output logic                        o_branch_taken,
	output logic [isa_pkg::NB_DATA-1:0] o_branch_target,
	output logic [isa_pkg::NB_DATA-1:0] o_jump_target,
	output logic                        o_pc_write,
	output logic                        o_if_id_write,
	output logic                        o_halted,
	output pipe_pkg::dbg_rsp_t          o_dbg
);

	pipe_pkg::ctrl_t             ctrl;
	pipe_pkg::id_ex_t            id_ex_next;
	logic                        beq;
	logic                        bne;
	logic                        jump;
	logic                        halt;
	logic                        imm_zero;
	logic                        stall;
	logic                        dbg_sel;
	logic [isa_pkg::NB_REG-1:0]  dbg_addr;
	logic [isa_pkg::NB_REG-1:0]  addr_a;
	logic [isa_pkg::NB_DATA-1:0] data_a;
	logic [isa_pkg::NB_DATA-1:0] data_b;
	logic [isa_pkg::NB_DATA-1:0] imm_ext;

	control_decoder u_control (.i_instr(i_instr), .o_ctrl(ctrl), .o_beq(beq), .o_bne(bne),
		.o_jump(jump), .o_halt(halt), .o_imm_zero(imm_zero));

	hazard_detector u_hazard (.i_rs(i_instr.r.rs), .i_rt(i_instr.r.rt), .i_ex_rt(i_ex_rt),
		.i_ex_mem_read(i_ex_mem_read), .i_halt(halt), .i_halted(o_halted), .o_stall(stall),
		.o_pc_write(o_pc_write), .o_if_id_write(o_if_id_write));

	assign addr_a = dbg_sel ? dbg_addr : i_instr.r.rs;   // Host owns port A after halt

	register_file u_regs (.i_clock(i_clock), .i_reset(i_reset), .i_wb(i_wb),
		.i_addr_a(addr_a), .i_addr_b(i_instr.r.rt), .o_data_a(data_a), .o_data_b(data_b));

	branch_resolver u_branch (.i_instr(i_instr), .i_pc_plus4(i_pc_plus4), .i_data_a(data_a),
		.i_data_b(data_b), .i_forward_a(i_forward_a), .i_forward_b(i_forward_b),
		.i_ex_mem_data(i_ex_mem_data), .i_beq(beq), .i_bne(bne), .i_jump(jump),
		.i_imm_zero(imm_zero), .o_imm_ext(imm_ext), .o_taken(o_branch_taken),
		.o_branch_target(o_branch_target), .o_jump_target(o_jump_target));

	always_comb
	begin
		id_ex_next.rs      = i_instr.r.rs;
		id_ex_next.rt      = i_instr.r.rt;
		id_ex_next.rd      = i_instr.r.rd;
		id_ex_next.shamt   = i_instr.r.shamt;
		id_ex_next.funct   = i_instr.r.funct;         // Passed through to EX
		id_ex_next.data_a  = data_a;
		id_ex_next.data_b  = data_b;
		id_ex_next.imm_ext = imm_ext;
		id_ex_next.ctrl    = ctrl;
	end

	id_ex_register u_id_ex (.i_clock(i_clock), .i_reset(i_reset), .i_enable(i_enable),
		.i_stall(stall), .i_id_ex(id_ex_next), .o_id_ex(o_id_ex));

	// Drain starts on the edge that latches HALT into ID/EX
	drain_timer #(.DRAIN_CYCLES(DRAIN_CYCLES)) u_drain (.i_clock(i_clock), .i_reset(i_reset),
		.i_halt(halt && i_enable), .o_halted(o_halted));

	debug_controller u_debug (.i_clock(i_clock), .i_reset(i_reset), .i_halted(o_halted),
		.i_dbg(i_dbg), .i_data_a(data_a), .o_dbg(o_dbg), .o_addr_sel(dbg_sel),
		.o_addr(dbg_addr));

endmodule

/* debug_controller.sv */
`timescale 1ns/100ps
module debug_controller
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_halted,
	input  pipe_pkg::dbg_req_t          i_dbg,            // From debug host
	input  logic [isa_pkg::NB_DATA-1:0] i_data_a,         // Bank port A
	output pipe_pkg::dbg_rsp_t          o_dbg,
	output logic                        o_addr_sel,       // Port A driven by host
	output logic [isa_pkg::NB_REG-1:0]  o_addr
);

	typedef enum logic [1:0] {IDLE, READ, ACK, RELEASE} state_t;

	state_t                      state;
	logic [isa_pkg::NB_DATA-1:0] rd_data;                 // Held for the host

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:    if (i_dbg.req && i_halted) state <= READ;   // Early req waits here
				READ:    state <= ACK;
				ACK:     if (!i_dbg.req) state <= RELEASE;
				RELEASE: state <= IDLE;                              // ack low, link idle
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (state == READ)
		begin
			rd_data <= i_data_a;
		end
	end

	assign o_addr_sel = i_halted;                     // Port A is free once drained
	assign o_addr     = i_dbg.addr;
	assign o_dbg      = '{ack: (state == ACK), data: rd_data};

endmodule

/* drain_timer.sv */
`timescale 1ns/100ps
module drain_timer
#(
	parameter int DRAIN_CYCLES = 3                    // Edges for later stages to empty
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_halt,                              // HALT being captured this edge
	output logic o_halted
);

	localparam int NB_COUNT = (DRAIN_CYCLES > 0) ? $clog2(DRAIN_CYCLES + 1) : 1;

	logic                running;                     // Drain in progress or done
	logic [NB_COUNT-1:0] count;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			running  <= 1'b0;
			count    <= '0;
			o_halted <= 1'b0;
		end
		else if (!running)
		begin
			running <= i_halt;
		end
		else if (count == NB_COUNT'(DRAIN_CYCLES))
		begin
			o_halted <= 1'b1;                         // Sticky until reset
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

endmodule

/* id_ex_register.sv */
`timescale 1ns/100ps
module id_ex_register
(
	input  logic             i_clock,
	input  logic             i_reset,
	input  logic             i_enable,                // Pipeline advance
	input  logic             i_stall,                 // Load-use bubble request
	input  pipe_pkg::id_ex_t i_id_ex,
	output pipe_pkg::id_ex_t o_id_ex
);

	pipe_pkg::id_ex_t next_id_ex;

	// Bubble keeps the fields but kills every control bit
	always_comb
	begin
		next_id_ex = i_id_ex;
		if (i_stall)
		begin
			next_id_ex.ctrl = '0;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_id_ex <= '0;
		end
		else if (i_enable)
		begin
			o_id_ex <= next_id_ex;                    // Latency of one cycle
		end
	end

endmodule

/* branch_resolver.sv */
`timescale 1ns/100ps
module branch_resolver
(
	input  isa_pkg::instr_u             i_instr,
	input  logic [isa_pkg::NB_DATA-1:0] i_pc_plus4,
	input  logic [isa_pkg::NB_DATA-1:0] i_data_a,         // Register bank read ports
	input  logic [isa_pkg::NB_DATA-1:0] i_data_b,
	input  logic                        i_forward_a,
	input  logic                        i_forward_b,
	input  logic [isa_pkg::NB_DATA-1:0] i_ex_mem_data,    // Result waiting in EX/MEM
	input  logic                        i_beq,
	input  logic                        i_bne,
	input  logic                        i_jump,
	input  logic                        i_imm_zero,
	output logic [isa_pkg::NB_DATA-1:0] o_imm_ext,
	output logic                        o_taken,
	output logic [isa_pkg::NB_DATA-1:0] o_branch_target,
	output logic [isa_pkg::NB_DATA-1:0] o_jump_target
);

	localparam int NB_EXT = isa_pkg::NB_DATA - isa_pkg::NB_IMM;

	logic [isa_pkg::NB_DATA-1:0] imm_sext;
	logic [isa_pkg::NB_DATA-1:0] opnd_a;
	logic [isa_pkg::NB_DATA-1:0] opnd_b;
	logic                        equal;

	assign imm_sext  = {{NB_EXT{i_instr.i.imm16[isa_pkg::NB_IMM-1]}}, i_instr.i.imm16};
	assign o_imm_ext = i_imm_zero ? {{NB_EXT{1'b0}}, i_instr.i.imm16} : imm_sext;

	assign opnd_a = i_forward_a ? i_ex_mem_data : i_data_a;   // Forward wins over bank
	assign opnd_b = i_forward_b ? i_ex_mem_data : i_data_b;
	assign equal  = (opnd_a == opnd_b);

	assign o_branch_target = i_pc_plus4 + (imm_sext << 2);    // Word offset from PC+4
	assign o_jump_target   = {i_pc_plus4[isa_pkg::NB_DATA-1 -: 4], i_instr.j.target26, 2'b00};
	assign o_taken         = (i_beq && equal) || (i_bne && !equal) || i_jump;

endmodule

/* register_file.sv */
`timescale 1ns/100ps
module register_file
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  pipe_pkg::wb_port_t          i_wb,             // Write port from WB
	input  logic [isa_pkg::NB_REG-1:0]  i_addr_a,
	input  logic [isa_pkg::NB_REG-1:0]  i_addr_b,
	output logic [isa_pkg::NB_DATA-1:0] o_data_a,
	output logic [isa_pkg::NB_DATA-1:0] o_data_b
);

	localparam int NB_DEPTH = 2**isa_pkg::NB_REG;

	logic [isa_pkg::NB_DATA-1:0] regs [NB_DEPTH];
	logic                        wr_valid;                // Write that actually lands

	assign wr_valid = i_wb.we && (i_wb.addr != '0);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			for (int idx = 0; idx < NB_DEPTH; idx++)
				regs[idx] <= '0;
		end
		else if (wr_valid)
		begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// Same-cycle write bypasses the array, r0 forced to zero
	assign o_data_a = (i_addr_a == '0)                   ? '0        :
	                  (wr_valid && i_wb.addr == i_addr_a) ? i_wb.data :
	                  regs[i_addr_a];
	assign o_data_b = (i_addr_b == '0)                   ? '0        :
	                  (wr_valid && i_wb.addr == i_addr_b) ? i_wb.data :
	                  regs[i_addr_b];

endmodule

/* hazard_detector.sv */
`timescale 1ns/100ps
module hazard_detector
(
	input  logic [isa_pkg::NB_REG-1:0] i_rs,              // Sources of the word in ID
	input  logic [isa_pkg::NB_REG-1:0] i_rt,
	input  logic [isa_pkg::NB_REG-1:0] i_ex_rt,           // Load destination now in EX
	input  logic                       i_ex_mem_read,
	input  logic                       i_halt,
	input  logic                       i_halted,
	output logic                       o_stall,
	output logic                       o_pc_write,
	output logic                       o_if_id_write
);

	logic rt_match;                                       // EX load feeds a source
	logic hold;

	assign rt_match = (i_ex_rt == i_rs) || (i_ex_rt == i_rt);

	// r0 is never a real dependency
	assign o_stall = i_ex_mem_read && (i_ex_rt != '0) && rt_match;

	// IF/ID keeps the HALT word, so i_halt covers the drain until i_halted takes over
	assign hold = o_stall || i_halt || i_halted;

	assign o_pc_write    = !hold;
	assign o_if_id_write = !hold;

endmodule

/* control_decoder.sv */
`timescale 1ns/100ps
module control_decoder
(
	input  isa_pkg::instr_u i_instr,
	output pipe_pkg::ctrl_t o_ctrl,
	output logic            o_beq,
	output logic            o_bne,
	output logic            o_jump,
	output logic            o_halt,
	output logic            o_imm_zero
);

	always_comb
	begin
		o_ctrl     = '0;                            // Unknown opcode stays a bubble
		o_beq      = 1'b0;
		o_bne      = 1'b0;
		o_jump     = 1'b0;
		o_halt     = 1'b0;
		o_imm_zero = 1'b0;
		case (i_instr.r.opcode)
			isa_pkg::OP_RTYPE:
			begin
				o_ctrl.ex.reg_dst   = 1'b1;         // Destination is rd
				o_ctrl.ex.alu_op    = pipe_pkg::ALU_FUNCT;
				o_ctrl.wb.reg_write = 1'b1;
			end
			isa_pkg::OP_ADDI:
			begin
				o_ctrl.ex.alu_src   = 1'b1;
				o_ctrl.ex.alu_op    = pipe_pkg::ALU_ADD;
				o_ctrl.wb.reg_write = 1'b1;
			end
			isa_pkg::OP_ANDI, isa_pkg::OP_ORI:
			begin
				o_ctrl.ex.alu_src   = 1'b1;
				o_ctrl.ex.alu_op    = (i_instr.r.opcode == isa_pkg::OP_ANDI) ?
					pipe_pkg::ALU_AND : pipe_pkg::ALU_OR;
				o_ctrl.wb.reg_write = 1'b1;
				o_imm_zero          = 1'b1;         // Logical ops zero-extend
			end
			isa_pkg::OP_LW:
			begin
				o_ctrl.ex.alu_src    = 1'b1;
				o_ctrl.ex.alu_op     = pipe_pkg::ALU_ADD;
				o_ctrl.mem.mem_read  = 1'b1;
				o_ctrl.wb.reg_write  = 1'b1;
				o_ctrl.wb.mem_to_reg = 1'b1;
			end
			isa_pkg::OP_SW:
			begin
				o_ctrl.ex.alu_src    = 1'b1;
				o_ctrl.ex.alu_op     = pipe_pkg::ALU_ADD;
				o_ctrl.mem.mem_write = 1'b1;
			end
			isa_pkg::OP_BEQ:
			begin
				o_ctrl.ex.alu_op = pipe_pkg::ALU_SUB;
				o_beq            = 1'b1;            // Resolved here in ID
			end
			isa_pkg::OP_BNE:
			begin
				o_ctrl.ex.alu_op = pipe_pkg::ALU_SUB;
				o_bne            = 1'b1;
			end
			isa_pkg::OP_J:    o_jump = 1'b1;
			isa_pkg::OP_HALT: o_halt = 1'b1;        // No control goes down the pipe
			default:          o_ctrl = '0;
		endcase
	end

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

	localparam logic [2:0] ALU_ADD   = 3'b000;      // Address calc and ADDI
	localparam logic [2:0] ALU_SUB   = 3'b001;      // Branch compare
	localparam logic [2:0] ALU_FUNCT = 3'b010;      // EX decodes funct
	localparam logic [2:0] ALU_AND   = 3'b011;
	localparam logic [2:0] ALU_OR    = 3'b100;

	typedef struct packed {
		logic       reg_dst;                        // Write rd instead of rt
		logic       alu_src;                        // B operand is imm_ext
		logic [2:0] alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;                           // Writeback from load data
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_t;

	typedef struct packed {
		logic [isa_pkg::NB_REG-1:0]   rs;
		logic [isa_pkg::NB_REG-1:0]   rt;
		logic [isa_pkg::NB_REG-1:0]   rd;
		logic [isa_pkg::NB_SHAMT-1:0] shamt;
		logic [isa_pkg::NB_FUNCT-1:0] funct;
		logic [isa_pkg::NB_DATA-1:0]  data_a;
		logic [isa_pkg::NB_DATA-1:0]  data_b;
		logic [isa_pkg::NB_DATA-1:0]  imm_ext;
		ctrl_t                        ctrl;
	} id_ex_t;

	typedef struct packed {
		logic                       req;
		logic [isa_pkg::NB_REG-1:0] addr;           // Stable while req is high
	} dbg_req_t;

	typedef struct packed {
		logic                        ack;
		logic [isa_pkg::NB_DATA-1:0] data;          // Valid while ack is high
	} dbg_rsp_t;

	typedef struct packed {
		logic                        we;
		logic [isa_pkg::NB_REG-1:0]  addr;
		logic [isa_pkg::NB_DATA-1:0] data;
	} wb_port_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

	localparam int NB_DATA   = 32;                  // Data word width
	localparam int NB_REG    = 5;                   // Register index width
	localparam int NB_OPCODE = 6;
	localparam int NB_SHAMT  = 5;
	localparam int NB_FUNCT  = 6;
	localparam int NB_IMM    = 16;
	localparam int NB_TARGET = 26;                  // J-type word index

	localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
	localparam logic [NB_OPCODE-1:0] OP_J     = 6'h02;
	localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
	localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
	localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
	localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0C;
	localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0D;
	localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
	localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2B;
	localparam logic [NB_OPCODE-1:0] OP_HALT  = 6'h3F;  // Stops fetch, starts drain

	// R-type funct codes, carried to EX untouched
	localparam logic [NB_FUNCT-1:0] FN_SLL = 6'h00;
	localparam logic [NB_FUNCT-1:0] FN_ADD = 6'h20;
	localparam logic [NB_FUNCT-1:0] FN_SUB = 6'h22;
	localparam logic [NB_FUNCT-1:0] FN_AND = 6'h24;
	localparam logic [NB_FUNCT-1:0] FN_OR  = 6'h25;

	typedef struct packed {
		logic [NB_OPCODE-1:0] opcode;
		logic [NB_REG-1:0]    rs;
		logic [NB_REG-1:0]    rt;
		logic [NB_REG-1:0]    rd;
		logic [NB_SHAMT-1:0]  shamt;
		logic [NB_FUNCT-1:0]  funct;
	} r_fmt_t;

	typedef struct packed {
		logic [NB_OPCODE-1:0] opcode;
		logic [NB_REG-1:0]    rs;
		logic [NB_REG-1:0]    rt;
		logic [NB_IMM-1:0]    imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [NB_OPCODE-1:0] opcode;
		logic [NB_TARGET-1:0] target26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;                                  // Register format
		i_fmt_t i;                                  // Immediate and branch format
		j_fmt_t j;                                  // Jump format
	} instr_u;

endpackage
